// File: bench/rv_single_core_tb.sv
`timescale 1ns/100ps

module rv_single_core_tb import rv_pkg::*; ();

    localparam int imem_words   = 256;
    localparam int dmem_words   = 256;
    localparam int halt_timeout = 200;

    logic            CLK, RST;
    logic            psel, penable, pwrite;
    logic [11:0]     paddr;
    logic [xlen-1:0] pwdata, prdata;
    logic            pready, pslverr;

    logic [xlen-1:0] model_regs [32];          // Expected architectural registers
    logic [xlen-1:0] dmem_model [dmem_words];  // Expected data memory
    logic [xlen-1:0] prog [$];                 // Program under construction
    integer          seed;

    rv_single_core #(
        .imem_words (imem_words),
        .dmem_words (dmem_words)
    ) dut (
        .CLK     (CLK),
        .RST     (RST),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #2 CLK = ~CLK;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    // One setup and one access phase, response sampled in the access phase
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [xlen-1:0] wdata,
                              output logic [xlen-1:0] rdata, output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge CLK);
        penable = 1'b1;
        check_flag("pready", pready, 1'b1);  // No wait states
        rdata = prdata;
        err   = pslverr;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [xlen-1:0] data);
        logic [xlen-1:0] rd;
        logic            err;
        apb_access(1'b1, addr, data, rd, err);
        check_flag($sformatf("pslverr (write 0x%h)", addr), err, 1'b0);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [xlen-1:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_flag($sformatf("pslverr (read 0x%h)", addr), err, 1'b0);
    endtask

    task automatic apb_write_expect_err(input logic [11:0] addr, input logic [xlen-1:0] data);
        logic [xlen-1:0] rd;
        logic            err;
        apb_access(1'b1, addr, data, rd, err);
        check_flag($sformatf("pslverr (write 0x%h)", addr), err, 1'b1);
    endtask

    // Instruction encoders
    function automatic logic [xlen-1:0] r_inst(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [xlen-1:0] i_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [xlen-1:0] lw_inst(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [4:0] rd);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    // RV32I semantics for the supported subset
    function automatic void model_exec(input logic [xlen-1:0] ins);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [4:0]      rd;
        logic [xlen-1:0] a, b, res, addr;
        opc = ins[6:0];
        f3  = ins[14:12];
        rd  = ins[11:7];
        a   = model_regs[ins[19:15]];
        b   = (opc == 7'b0110011) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        case (f3)
            3'd0: res = (opc == 7'b0110011 && ins[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: res = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (opc == 7'b0000011) begin
            addr = a + b;
            res  = dmem_model[addr[9:2]];  // Word index wraps over the window
        end
        if (rd != 5'd0)
            model_regs[rd] = res;
    endfunction

    function automatic void emit(input logic [xlen-1:0] ins);
        prog.push_back(ins);
        model_exec(ins);
    endfunction

    // Program words followed by a zero word that halts the core
    task automatic load_program();
        if (prog.size() >= imem_words)
            abort_run("Program does not fit in instruction memory");
        for (int i = 0; i < prog.size(); i++)
            apb_write(12'(imem_base + i * 4), prog[i]);
        apb_write(12'(imem_base + prog.size() * 4), '0);
    endtask

    task automatic wait_halted();
        logic [xlen-1:0] st;
        int              polls;
        st    = '0;
        polls = 0;
        while (!st[0]) begin
            if (polls >= halt_timeout)
                abort_run("Core did not halt within the poll limit");
            apb_read(status_addr, st);
            polls++;
        end
    endtask

    task automatic check_regs();
        logic [xlen-1:0] v;
        for (int r = 0; r < 32; r++) begin
            apb_read(12'(regs_base + r * 4), v);
            check_word($sformatf("x%0d", r), v, model_regs[r]);
        end
    endtask

    task automatic run_program();
        logic [xlen-1:0] v;
        load_program();
        apb_write(ctrl_addr, 32'd1);
        wait_halted();
        apb_read(pc_addr, v);
        check_word("pc", v, 32'(prog.size() * 4));  // Stops on the zero word
        apb_read(ctrl_addr, v);
        check_word("ctrl", v, '0);
        check_regs();
        prog.delete();
    endtask

    task automatic test_reset_state();
        logic [xlen-1:0] v;
        apb_read(ctrl_addr, v);
        check_word("ctrl", v, '0);
        apb_read(status_addr, v);
        check_word("status", v, '0);
        apb_read(pc_addr, v);
        check_word("pc", v, '0);
        check_regs();
    endtask

    task automatic test_reg_ops();
        emit(i_inst(12'd100, 0, f3_add, 1));
        emit(i_inst(12'(-37), 0, f3_add, 2));
        emit(i_inst(12'h7FF, 0, f3_add, 3));
        emit(i_inst(12'h800, 0, f3_add, 4));
        emit(i_inst(12'd5, 0, f3_add, 5));
        emit(i_inst(12'hFFF, 0, f3_add, 6));
        emit(r_inst(7'b0000000, 2, 1, f3_add, 7));
        emit(r_inst(7'b0100000, 1, 2, f3_add, 8));   // SUB
        emit(r_inst(7'b0000000, 5, 2, f3_sll, 9));
        emit(r_inst(7'b0000000, 1, 2, f3_slt, 10));
        emit(r_inst(7'b0000000, 1, 2, f3_sltu, 11));
        emit(r_inst(7'b0000000, 4, 2, f3_xor, 12));
        emit(r_inst(7'b0000000, 5, 2, f3_sr, 13));
        emit(r_inst(7'b0100000, 5, 2, f3_sr, 14));   // SRA
        emit(r_inst(7'b0000000, 3, 4, f3_or, 15));
        emit(r_inst(7'b0000000, 6, 3, f3_and, 16));
        run_program();
    endtask

    task automatic test_imm_ops();
        logic [11:0] imms [3];
        logic [2:0]  iops [6];
        logic [4:0]  srcs [3];
        logic [4:0]  shamts [3];
        int          k;
        imms   = '{12'h800, 12'hFFF, 12'h7FF};
        iops   = '{f3_add, f3_slt, f3_sltu, f3_xor, f3_or, f3_and};
        srcs   = '{5'd2, 5'd6, 5'd3};
        shamts = '{5'd0, 5'd7, 5'd31};
        k = 0;
        for (int o = 0; o < 6; o++) begin
            for (int m = 0; m < 3; m++) begin
                emit(i_inst(imms[m], srcs[(o + m) % 3], iops[o], 5'(17 + k % 15)));
                k++;
            end
        end
        for (int s = 0; s < 3; s++) begin
            emit(i_inst({7'b0000000, shamts[s]}, 2, f3_sll, 5'(17 + k % 15)));
            emit(i_inst({7'b0000000, shamts[s]}, 2, f3_sr, 5'(18 + k % 14)));
            emit(i_inst({7'b0100000, shamts[s]}, 2, f3_sr, 5'(19 + k % 13)));
            k += 3;
        end
        emit(i_inst(12'd5, 1, f3_add, 0));  // x0 must stay zero
        run_program();
    endtask

    task automatic test_loads();
        logic [xlen-1:0] v;
        int              idx [$];
        for (int i = 8; i < 32; i++)
            idx.push_back(i);
        idx.push_back(255);
        foreach (idx[i]) begin
            dmem_model[idx[i]] = $random(seed);
            apb_write(12'(dmem_base + idx[i] * 4), dmem_model[idx[i]]);
        end
        foreach (idx[i]) begin
            apb_read(12'(dmem_base + idx[i] * 4), v);
            check_word($sformatf("dmem[%0d]", idx[i]), v, dmem_model[idx[i]]);
        end
        emit(i_inst(12'd80, 0, f3_add, 20));  // Base at word 20
        emit(lw_inst(12'(-48), 20, 21));
        emit(lw_inst(12'(-20), 20, 22));
        emit(lw_inst(12'(-4), 20, 23));
        emit(lw_inst(12'd0, 20, 24));
        emit(lw_inst(12'd8, 20, 25));
        emit(lw_inst(12'd40, 20, 26));
        emit(lw_inst(12'(-4), 0, 27));        // Wraps to the last word
        emit(lw_inst(12'h7FF, 20, 28));
        emit(lw_inst(12'h800, 20, 29));
        run_program();
    endtask

    task automatic test_errors_and_stop();
        logic [xlen-1:0] v, prev;
        logic            err, wrapped;
        int              polls;
        apb_write_expect_err(12'h900, 32'h1234);
        apb_write_expect_err(12'h802, 32'h1);
        apb_write_expect_err(12'(regs_base + 4), 32'hDEAD);
        apb_access(1'b0, 12'h900, '0, v, err);
        check_flag("pslverr (read 0x900)", err, 1'b1);
        check_word("prdata (failed read)", v, '0);
        apb_access(1'b0, 12'(regs_base + 6), '0, v, err);  // Lands on x1, which is nonzero
        check_flag("pslverr (misaligned read)", err, 1'b1);
        check_word("prdata (misaligned read)", v, '0);
        for (int i = 0; i < imem_words; i++)
            apb_write(12'(imem_base + i * 4), i_inst(12'(i), 0, f3_add, 0));
        apb_write(ctrl_addr, 32'd1);
        apb_write_expect_err(imem_base, 32'h0);  // Program is locked while running
        prev    = '0;
        wrapped = 1'b0;
        polls   = 0;
        while (!wrapped) begin
            if (polls >= 400)
                abort_run("Free-running program never wrapped back to address 0");
            apb_read(pc_addr, v);
            wrapped = v < prev;
            prev    = v;
            polls++;
        end
        apb_read(status_addr, v);
        check_word("status", v, '0);
        apb_read(ctrl_addr, v);
        check_word("ctrl", v, 32'd1);
        apb_write(ctrl_addr, 32'd0);
        apb_read(ctrl_addr, v);
        check_word("ctrl", v, '0);
        apb_read(pc_addr, prev);
        apb_read(pc_addr, v);
        check_word("pc after stop", v, prev);
        check_regs();
    endtask

    task automatic test_random_ops();
        logic [xlen-1:0] rnd;
        logic [2:0]      f3;
        logic [11:0]     imm;
        for (int r = 1; r <= 8; r++) begin
            rnd = $random(seed);
            emit(i_inst(rnd[11:0], 0, f3_add, 5'(r)));
            emit(i_inst({7'b0000000, rnd[16:12]}, 5'(r), f3_sll, 5'(r)));
            emit(i_inst(rnd[31:20], 5'(r), f3_xor, 5'(r)));
        end
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            f3  = rnd[2:0];
            imm = rnd[31:20];
            if (rnd[19]) begin
                emit(r_inst((rnd[18] && (f3 == f3_add || f3 == f3_sr)) ? 7'b0100000 : 7'b0,
                            rnd[17:13], rnd[12:8], f3, rnd[7:3]));
            end else begin
                if (f3 == f3_sll)
                    imm = {7'b0000000, rnd[17:13]};
                else if (f3 == f3_sr)
                    imm = {rnd[18] ? 7'b0100000 : 7'b0000000, rnd[17:13]};
                emit(i_inst(imm, rnd[12:8], f3, rnd[7:3]));
            end
        end
        run_program();
    endtask

    initial begin
        CLK     = 1'b0;
        RST     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'hc22c;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        for (int i = 0; i < dmem_words; i++)
            dmem_model[i] = '0;
        repeat (5) @(negedge CLK);
        RST = 1'b0;

        $display("Test 1: reset state");
        test_reset_state();
        $display("Test 2: register-register operations");
        test_reg_ops();
        $display("Test 3: immediate operations");
        test_imm_ops();
        $display("Test 4: data memory and loads");
        test_loads();
        $display("Test 5: bus errors, wrap and stop");
        test_errors_and_stop();
        $display("Test 6: random instructions");
        test_random_ops();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_single_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module rv_single_core_tb \
    -f rv_single_core.f \
    -o rv_single_core_sim

# The simulator exit code is not trusted; the log decides
./obj_dir/rv_single_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "run_sim.sh: testbench reported failure"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim.sh: simulation ended without a pass report"
    exit 1
fi
echo "run_sim.sh: done"

// File: rv_single_core.f
verilog/rv_pkg.sv
verilog/rv_inst_mem.sv
verilog/rv_reg_file.sv
verilog/rv_int_alu.sv
verilog/rv_load_unit.sv
verilog/rv_core_ctrl.sv
verilog/rv_host_apb.sv
verilog/rv_single_core.sv
bench/rv_single_core_tb.sv

// File: verilog/rv_core_ctrl.sv
`timescale 1ns/100ps

module rv_core_ctrl import rv_pkg::*; #(
    parameter int imem_words = 256
) (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          run,
    input  logic                          start,
    input  logic [xlen-1:0]               inst,
    input  logic [xlen-1:0]               rs1_data,
    input  logic [xlen-1:0]               rs2_data,
    input  logic [xlen-1:0]               alu_result,
    input  logic [xlen-1:0]               load_data,
    output logic [$clog2(imem_words)-1:0] fetch_addr,
    output logic [xlen-1:0]               pc,
    output logic                          halted,
    output logic                          halt_req,
    output logic [4:0]                    rs1_addr,
    output logic [4:0]                    rs2_addr,
    output alu_op_e                       alu_op,
    output logic [xlen-1:0]               operand_b,
    output logic [xlen-1:0]               load_offset,
    output logic                          rd_we,
    output logic [4:0]                    rd_addr,
    output logic [xlen-1:0]               rd_data
);

    localparam int iaw = $clog2(imem_words);

    opcode_e         opcode;
    funct3_e         funct3;
    logic [6:0]      funct7;
    logic            f7_zero, f7_alt;
    logic            valid, active;
    logic [xlen-1:0] imm;
    logic [iaw-1:0]  pc_word;

    // Plain funct3 to ALU mapping, funct7 variants handled by the caller
    function automatic alu_op_e base_op(funct3_e f);
        case (f)
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return alu_srl;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign opcode   = opcode_e'(inst[6:0]);
    assign funct3   = funct3_e'(inst[14:12]);
    assign funct7   = inst[31:25];
    assign f7_zero  = funct7 == 7'b0000000;
    assign f7_alt   = funct7 == 7'b0100000;  // SUB / SRA marker
    assign imm      = {{20{inst[31]}}, inst[31:20]};
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];

    always_comb begin
        valid  = 1'b0;
        alu_op = alu_add;
        case (opcode)
            op_reg: begin
                if (funct3 == f3_add || funct3 == f3_sr) begin
                    alu_op = (funct3 == f3_add) ? (f7_alt ? alu_sub : alu_add)
                                                : (f7_alt ? alu_sra : alu_srl);
                    valid  = f7_zero | f7_alt;
                end else begin
                    alu_op = base_op(funct3);
                    valid  = f7_zero;
                end
            end
            op_imm: begin
                alu_op = base_op(funct3);
                valid  = 1'b1;
                if (funct3 == f3_sll) begin
                    valid = f7_zero;
                end else if (funct3 == f3_sr) begin
                    alu_op = f7_alt ? alu_sra : alu_srl;
                    valid  = f7_zero | f7_alt;
                end
            end
            op_load: valid = funct3 == f3_slt;  // LW only, narrower loads halt
            default: valid = 1'b0;
        endcase
    end

    // Core is held for the start cycle so pc is cleared first
    assign active   = run & ~halted & ~start;
    assign halt_req = active & ~valid;
    assign rd_we    = active & valid;

    assign operand_b   = (opcode == op_reg) ? rs2_data : imm;
    assign load_offset = imm;
    assign rd_data     = (opcode == op_load) ? load_data : alu_result;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc_word <= '0;
            halted  <= 1'b0;
        end else if (start) begin
            pc_word <= '0;
            halted  <= 1'b0;
        end else if (active) begin
            if (valid)
                pc_word <= pc_word + 1'b1;  // Wraps past the last word
            else
                halted <= 1'b1;  // pc stays on the offending word
        end
    end

    assign fetch_addr = pc_word;
    assign pc         = xlen'({pc_word, 2'b00});

endmodule

// File: verilog/rv_host_apb.sv
`timescale 1ns/100ps

module rv_host_apb import rv_pkg::*; #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [11:0]                   paddr,
    input  logic [xlen-1:0]               pwdata,
    output logic                          pready,
    output logic [xlen-1:0]               prdata,
    output logic                          pslverr,
    input  logic                          halted,
    input  logic [xlen-1:0]               pc,
    input  logic [xlen-1:0]               host_rdata,
    input  logic [xlen-1:0]               dmem_rdata,
    input  logic                          halt_req,
    output logic                          imem_we,
    output logic [$clog2(imem_words)-1:0] imem_waddr,
    output logic [xlen-1:0]               imem_wdata,
    output logic                          dmem_we,
    output logic [$clog2(dmem_words)-1:0] dmem_waddr,
    output logic [xlen-1:0]               dmem_wdata,
    output logic [$clog2(dmem_words)-1:0] dmem_raddr,
    output logic [4:0]                    reg_raddr,
    output logic                          run,
    output logic                          start
);

    localparam int iaw = $clog2(imem_words);
    localparam int daw = $clog2(dmem_words);

    logic            setup, access, wr_ok, ctrl_we;
    logic            in_imem, in_dmem, is_ctrl, is_status, is_pc, in_regs;
    logic            mapped, err;
    logic [xlen-1:0] rd_mux;

    assign setup  = psel & ~penable;
    assign access = psel & penable;
    assign pready = 1'b1;  // Never any wait states

    // Window decode, word index must fall inside the sized memory
    assign in_imem   = (paddr[11:10] == imem_base[11:10]) && (32'(paddr[9:2]) < imem_words);
    assign in_dmem   = (paddr[11:10] == dmem_base[11:10]) && (32'(paddr[9:2]) < dmem_words);
    assign is_ctrl   = paddr == ctrl_addr;
    assign is_status = paddr == status_addr;
    assign is_pc     = paddr == pc_addr;
    assign in_regs   = paddr[11:7] == regs_base[11:7];
    assign mapped    = in_imem | in_dmem | is_ctrl | is_status | is_pc | in_regs;

    assign err = (paddr[1:0] != 2'b00) || !mapped
              || (pwrite && (is_status || is_pc || in_regs))  // Read-only locations
              || (pwrite && in_imem && run);                  // Program locked while running

    // Instruction memory has no host read path, reads there give zero
    always_comb begin
        if (in_dmem)        rd_mux = dmem_rdata;
        else if (is_ctrl)   rd_mux = xlen'(run);
        else if (is_status) rd_mux = xlen'(halted);
        else if (is_pc)     rd_mux = pc;
        else if (in_regs)   rd_mux = host_rdata;
        else                rd_mux = '0;
    end

    // Response is captured at the end of setup, valid through access
    always_ff @(posedge CLK) begin
        if (RST) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup) begin
            pslverr <= err;
            prdata  <= (err || pwrite) ? '0 : rd_mux;
        end
    end

    assign wr_ok   = access & pwrite & ~pslverr;  // Failed writes are dropped
    assign imem_we = wr_ok & in_imem;
    assign dmem_we = wr_ok & in_dmem;
    assign ctrl_we = wr_ok & is_ctrl;

    assign imem_waddr = paddr[iaw+1:2];
    assign imem_wdata = pwdata;
    assign dmem_waddr = paddr[daw+1:2];
    assign dmem_wdata = pwdata;
    assign dmem_raddr = paddr[daw+1:2];
    assign reg_raddr  = paddr[6:2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            run   <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (ctrl_we) begin
                if (pwdata[0] && !run) begin
                    run   <= 1'b1;
                    start <= 1'b1;  // Restart from address 0
                end else if (!pwdata[0]) begin
                    run <= 1'b0;
                end
            end
            if (halt_req)
                run <= 1'b0;  // Core hit an unsupported instruction
        end
    end

endmodule

// File: verilog/rv_inst_mem.sv
`timescale 1ns/100ps

module rv_inst_mem import rv_pkg::*; #(
    parameter int imem_words = 256
) (
    input  logic                          CLK,
    input  logic                          imem_we,
    input  logic [$clog2(imem_words)-1:0] imem_waddr,
    input  logic [xlen-1:0]               imem_wdata,
    input  logic [$clog2(imem_words)-1:0] fetch_addr,
    output logic [xlen-1:0]               inst
);

    logic [xlen-1:0] mem [imem_words];

    // Host loads the program one word at a time
    always_ff @(posedge CLK) begin
        if (imem_we)
            mem[imem_waddr] <= imem_wdata;
    end

    assign inst = mem[fetch_addr];  // Asynchronous fetch

endmodule

// File: verilog/rv_int_alu.sv
`timescale 1ns/100ps

module rv_int_alu import rv_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic [xlen-1:0] operand_a,
    input  logic [xlen-1:0] operand_b,
    output logic [xlen-1:0] alu_result
);

    logic [4:0] shamt;

    assign shamt = operand_b[4:0];  // RV32 shifts use 5 bits only

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = operand_a + operand_b;
            alu_sub:  alu_result = operand_a - operand_b;
            alu_sll:  alu_result = operand_a << shamt;
            alu_slt:  alu_result = xlen'($signed(operand_a) < $signed(operand_b));
            alu_sltu: alu_result = xlen'(operand_a < operand_b);
            alu_xor:  alu_result = operand_a ^ operand_b;
            alu_srl:  alu_result = operand_a >> shamt;
            alu_sra:  alu_result = $signed(operand_a) >>> shamt;  // Sign fill
            alu_or:   alu_result = operand_a | operand_b;
            alu_and:  alu_result = operand_a & operand_b;
            default:  alu_result = '0;
        endcase
    end

endmodule

// File: verilog/rv_load_unit.sv
`timescale 1ns/100ps

module rv_load_unit import rv_pkg::*; #(
    parameter int dmem_words = 256
) (
    input  logic                          CLK,
    input  logic                          dmem_we,
    input  logic [$clog2(dmem_words)-1:0] dmem_waddr,
    input  logic [xlen-1:0]               dmem_wdata,
    input  logic [$clog2(dmem_words)-1:0] dmem_raddr,
    output logic [xlen-1:0]               dmem_rdata,
    input  logic [xlen-1:0]               base,
    input  logic [xlen-1:0]               offset,
    output logic [xlen-1:0]               load_data
);

    localparam int daw = $clog2(dmem_words);

    logic [xlen-1:0] mem [dmem_words];
    logic [daw+1:0]  eff_addr;
    logic [daw-1:0]  load_idx;

    // Host write port, the core has no stores
    always_ff @(posedge CLK) begin
        if (dmem_we)
            mem[dmem_waddr] <= dmem_wdata;
    end

    // Only the bits that reach the word index are summed
    assign eff_addr = base[daw+1:0] + offset[daw+1:0];
    assign load_idx = eff_addr[daw+1:2];  // Byte offset ignored, wraps modulo size

    assign load_data  = mem[load_idx];
    assign dmem_rdata = mem[dmem_raddr];  // Host read port

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;  // Fixed by RV32I

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        op_reg  = 7'b0110011,
        op_imm  = 7'b0010011,
        op_load = 7'b0000011
    } opcode_e;

    // funct3 codes of the OP / OP-IMM groups
    typedef enum logic [2:0] {
        f3_add  = 3'b000,
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,  // Also the LW width code
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,  // SRL or SRA, picked by funct7
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } funct3_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Host address map, byte addresses
    localparam logic [11:0] imem_base   = 12'h000;  // 0x000-0x3FF
    localparam logic [11:0] dmem_base   = 12'h400;  // 0x400-0x7FF
    localparam logic [11:0] ctrl_addr   = 12'h800;
    localparam logic [11:0] status_addr = 12'h804;
    localparam logic [11:0] pc_addr     = 12'h808;
    localparam logic [11:0] regs_base   = 12'hC00;  // 0xC00-0xC7F

endpackage

// File: verilog/rv_reg_file.sv
`timescale 1ns/100ps

module rv_reg_file import rv_pkg::*; (
    input  logic            CLK,
    input  logic            RST,
    input  logic [4:0]      rs1_addr,
    input  logic [4:0]      rs2_addr,
    input  logic [4:0]      reg_raddr,
    output logic [xlen-1:0] rs1_data,
    output logic [xlen-1:0] rs2_data,
    output logic [xlen-1:0] host_rdata,
    input  logic            rd_we,
    input  logic [4:0]      rd_addr,
    input  logic [xlen-1:0] rd_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;  // x0 is never written
        end
    end

    // Hardwired zero on every read port
    assign rs1_data   = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data   = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];
    assign host_rdata = (reg_raddr == 5'd0) ? '0 : regs[reg_raddr];

endmodule

// File: verilog/rv_single_core.sv
`timescale 1ns/100ps

module rv_single_core import rv_pkg::*; #(
    parameter int imem_words = 256,
    parameter int dmem_words = 256
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [11:0]     paddr,
    input  logic [xlen-1:0] pwdata,
    output logic [xlen-1:0] prdata,
    output logic            pready,
    output logic            pslverr
);

    localparam int iaw = $clog2(imem_words);
    localparam int daw = $clog2(dmem_words);

    // Host side
    logic            imem_we, dmem_we;
    logic [iaw-1:0]  imem_waddr;
    logic [daw-1:0]  dmem_waddr, dmem_raddr;
    logic [xlen-1:0] imem_wdata, dmem_wdata, dmem_rdata, host_rdata;
    logic [4:0]      reg_raddr;
    logic            run, start, halted, halt_req;
    logic [xlen-1:0] pc;

    // Core side
    logic [iaw-1:0]  fetch_addr;
    logic [xlen-1:0] inst;
    logic [4:0]      rs1_addr, rs2_addr, rd_addr;
    logic [xlen-1:0] rs1_data, rs2_data, rd_data;
    alu_op_e         alu_op;
    logic [xlen-1:0] operand_b, alu_result;
    logic [xlen-1:0] load_offset, load_data;
    logic            rd_we;

    rv_host_apb #(
        .imem_words (imem_words),
        .dmem_words (dmem_words)
    ) u_host (
        .CLK        (CLK),
        .RST        (RST),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pready     (pready),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .halted     (halted),
        .pc         (pc),
        .host_rdata (host_rdata),
        .dmem_rdata (dmem_rdata),
        .halt_req   (halt_req),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .dmem_we    (dmem_we),
        .dmem_waddr (dmem_waddr),
        .dmem_wdata (dmem_wdata),
        .dmem_raddr (dmem_raddr),
        .reg_raddr  (reg_raddr),
        .run        (run),
        .start      (start)
    );

    rv_inst_mem #(
        .imem_words (imem_words)
    ) u_imem (
        .CLK        (CLK),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .fetch_addr (fetch_addr),
        .inst       (inst)
    );

    rv_reg_file u_regs (
        .CLK        (CLK),
        .RST        (RST),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .reg_raddr  (reg_raddr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .host_rdata (host_rdata),
        .rd_we      (rd_we),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    rv_int_alu u_alu (
        .alu_op     (alu_op),
        .operand_a  (rs1_data),
        .operand_b  (operand_b),
        .alu_result (alu_result)
    );

    rv_load_unit #(
        .dmem_words (dmem_words)
    ) u_load (
        .CLK        (CLK),
        .dmem_we    (dmem_we),
        .dmem_waddr (dmem_waddr),
        .dmem_wdata (dmem_wdata),
        .dmem_raddr (dmem_raddr),
        .dmem_rdata (dmem_rdata),
        .base       (rs1_data),
        .offset     (load_offset),
        .load_data  (load_data)
    );

    rv_core_ctrl #(
        .imem_words (imem_words)
    ) u_ctrl (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .start       (start),
        .inst        (inst),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .load_data   (load_data),
        .fetch_addr  (fetch_addr),
        .pc          (pc),
        .halted      (halted),
        .halt_req    (halt_req),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .alu_op      (alu_op),
        .operand_b   (operand_b),
        .load_offset (load_offset),
        .rd_we       (rd_we),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule
